//--- vdp.f
logic/vdp_pkg.sv
logic/vdp_vram_req_if.sv
logic/vdp_vga_timing.sv
logic/vdp_register_file.sv
logic/vdp_vram_schedule.sv
logic/vdp_palette.sv
logic/vdp.sv
test/vdp_sva.sv
test/vdp_checker.sv
test/vdp_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the display processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vdp_tb \
    -f vdp.f --Mdir obj_dir -o vdp_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/vdp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0

//--- test/vdp_tb.sv
// testbench for the display processor core
// applies a table of host register steps and reports the scoreboard result
`timescale 1ns/1ps

module vdp_tb;
    import vdp_pkg::*;

    typedef enum {STEP_WRITE, STEP_DATA, STEP_READ, STEP_LINES, STEP_COLOR} step_kind_e;

    // expected holds the VRAM word address of a data step, or the palette index of a colour step
    typedef struct {
        string name;
        step_kind_e kind;
        reg_addr_t reg_number;
        word_t data;
        int expected;
    } step_t;

    localparam int sig_ready = 0;
    localparam int sig_line = 1;
    localparam int sig_frame = 2;
    localparam int sig_active = 3;
    localparam int frame_clocks = 525 * 800;

    logic clk;
    logic reset;
    reg_addr_t host_address;
    word_t host_write_data;
    logic host_write_en;
    logic host_read_en;
    word_t host_read_data;
    logic host_ready;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    logic vga_hsync;
    logic vga_vsync;
    logic active_display;
    logic line_ended;
    logic frame_ended;
    logic active_frame_ended;
    vram_addr_t vram_address_even;
    word_t vram_write_data_even;
    logic vram_we_even;
    vram_addr_t vram_address_odd;
    word_t vram_write_data_odd;
    logic vram_we_odd;

    step_t steps[$];
    word_t palette_shadow[256];
    pal_addr_t palette_pointer = '0;
    int timeout_count = 0;

    vdp #(
        .enable_widescreen(1'b0)
    ) DUT (.*);

    vdp_checker scoreboard (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic probe(input int which);
        case (which)
            sig_ready: return host_ready;
            sig_line: return line_ended;
            sig_frame: return frame_ended;
            default: return active_display;
        endcase
    endfunction

    task automatic wait_for(input int which, input logic level, input int limit,
        input string what);
        int waited;
        waited = 0;
        while (timeout_count == 0 && probe(which) !== level) begin
            if (waited == limit) begin
                $display("Timeout: %s did not happen within %0d clocks", what, limit);
                timeout_count++;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic drive_write(input reg_addr_t number, input word_t value);
        host_address = number;
        host_write_data = value;
        host_write_en = 1'b1;
        @(negedge clk);
        host_write_en = 1'b0;
    endtask

    task automatic drive_read(input reg_addr_t number);
        host_address = number;
        host_read_en = 1'b1;
        @(negedge clk);
        host_read_en = 1'b0;
        @(negedge clk);
    endtask

    task automatic add_step(input string name, input step_kind_e kind, input reg_addr_t number,
        input word_t data, input int expected);
        step_t s;
        s.name = name;
        s.kind = kind;
        s.reg_number = number;
        s.data = data;
        s.expected = expected;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step("vram address", STEP_WRITE, REG_VRAM_ADDR, 16'h0ffe, 0);
        add_step("vram increment 1", STEP_WRITE, REG_VRAM_INCREMENT, 16'h0001, 0);
        add_step("vram data even", STEP_DATA, REG_VRAM_DATA, 16'h0000, 'h0ffe);
        add_step("vram data odd", STEP_DATA, REG_VRAM_DATA, 16'h0000, 'h0fff);
        add_step("vram data carry", STEP_DATA, REG_VRAM_DATA, 16'h0000, 'h1000);
        add_step("vram increment 129", STEP_WRITE, REG_VRAM_INCREMENT, 16'h0081, 0);
        add_step("vram address high", STEP_WRITE, REG_VRAM_ADDR, 16'h7fc0, 0);
        add_step("vram data top", STEP_DATA, REG_VRAM_DATA, 16'h0000, 'h7fc0);
        add_step("vram data wrap", STEP_DATA, REG_VRAM_DATA, 16'h0000, 'h0041);
        add_step("vram data after wrap", STEP_DATA, REG_VRAM_DATA, 16'h0000, 'h00c2);
        add_step("raster x read", STEP_READ, READ_RASTER_X, 16'h0000, 0);
        add_step("skip lines", STEP_LINES, REG_VRAM_ADDR, 16'd37, 0);
        add_step("raster y read", STEP_READ, READ_RASTER_Y, 16'h0000, 0);
        add_step("raster x late read", STEP_READ, READ_RASTER_X, 16'h0000, 0);
        add_step("palette address", STEP_WRITE, REG_PALETTE_ADDR, 16'h00ff, 0);
        add_step("palette word x", STEP_DATA, REG_PALETTE_DATA, 16'h0000, 0);
        add_step("palette word y", STEP_DATA, REG_PALETTE_DATA, 16'h0000, 0);
        add_step("backdrop colour", STEP_COLOR, REG_PALETTE_ADDR, 16'h0000, 0);
    endtask

    task automatic run_step(input step_t s);
        word_t word;
        int pulses;
        scoreboard.start_step(s.name);
        case (s.kind)
            STEP_WRITE: begin
                if (s.reg_number == REG_PALETTE_ADDR) begin
                    palette_pointer = s.data[7:0];
                end
                drive_write(s.reg_number, s.data);
            end
            STEP_DATA: begin
                word = word_t'($urandom());
                if (s.reg_number == REG_PALETTE_DATA) begin
                    // palette index wraps at 256
                    palette_shadow[palette_pointer] = word;
                    palette_pointer = palette_pointer + 1'b1;
                    drive_write(s.reg_number, word);
                end else begin
                    wait_for(sig_ready, 1'b1, 16, "host_ready before a VRAM data write");
                    scoreboard.expect_port_write(32'(s.expected), 32'(word));
                    pulses = scoreboard.pulse_count;
                    drive_write(s.reg_number, word);
                    scoreboard.check_value("host_ready after data write", 0, 32'(host_ready));
                    wait_for(sig_ready, 1'b1, 9, "host_ready return after a VRAM data write");
                    // port pulse shares the edge where host_ready rises
                    @(negedge clk);
                    scoreboard.check_value("port pulses while busy", 1,
                        32'(scoreboard.pulse_count - pulses));
                end
            end
            STEP_READ: drive_read(s.reg_number);
            STEP_LINES: begin
                repeat (s.data) begin
                    wait_for(sig_line, 1'b1, 810, "line_ended");
                    @(negedge clk);
                end
            end
            default: begin
                wait_for(sig_active, 1'b0, 810, "end of active display");
                wait_for(sig_active, 1'b1, frame_clocks, "start of active display");
                // mid-line, well clear of the two-cycle output delay
                repeat (320) @(negedge clk);
                scoreboard.check_value("active colour",
                    32'(palette_shadow[s.expected][11:0]), 32'({r, g, b}));
                wait_for(sig_active, 1'b0, 810, "end of active display");
                repeat (40) @(negedge clk);
                scoreboard.check_value("blanking colour", 0, 32'({r, g, b}));
            end
        endcase
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", scoreboard.check_count,
            scoreboard.error_count, timeout_count);
        if (scoreboard.error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        void'($urandom(23));
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        scoreboard.start_step("reset state");
        scoreboard.check_value("host_ready", 1, 32'(host_ready));
        scoreboard.check_value("even write enable", 0, 32'(vram_we_even));
        scoreboard.check_value("odd write enable", 0, 32'(vram_we_odd));
        scoreboard.check_value("colour", 0, 32'({r, g, b}));

        // the scoreboard checks line and frame timing on its own
        scoreboard.start_step("first frame");
        wait_for(sig_frame, 1'b1, frame_clocks + 16, "first frame_ended");
        @(negedge clk);

        foreach (steps[i]) begin
            if (timeout_count == 0) begin
                run_step(steps[i]);
            end
        end

        scoreboard.start_step("second frame");
        wait_for(sig_frame, 1'b1, frame_clocks + 16, "second frame_ended");
        @(negedge clk);
        scoreboard.check_drained();
        finish_run();
    end

endmodule

//--- test/vdp_checker.sv
// scoreboard for the display processor
// tracks the raster from the strobes, checks line and frame timing,
// raster reads and VRAM port writes, and counts errors
`timescale 1ns/1ps

module vdp_checker (
    input logic clk,
    input logic reset,
    input vdp_pkg::reg_addr_t host_address,
    input logic host_read_en,
    input vdp_pkg::word_t host_read_data,
    input logic vga_hsync,
    input logic vga_vsync,
    input logic active_display,
    input logic line_ended,
    input logic frame_ended,
    input logic active_frame_ended,
    input vdp_pkg::vram_addr_t vram_address_even,
    input vdp_pkg::vram_addr_t vram_address_odd,
    input vdp_pkg::word_t vram_write_data_even,
    input vdp_pkg::word_t vram_write_data_odd,
    input logic vram_we_even,
    input logic vram_we_odd
);
    import vdp_pkg::*;

    // 640x480 raster
    localparam int line_clocks = 800;
    localparam int hsync_clocks = 96;
    localparam int active_width = 640;
    localparam int active_lines = 480;
    localparam int frame_lines = 525;
    localparam int vsync_lines_expected = 2;

    int check_count = 0;
    int error_count = 0;
    int pulse_count = 0;
    string step_name = "startup";
    logic [31:0] expected_addresses[$];
    logic [31:0] expected_words[$];
    int x_model;
    int y_model;
    int hsync_low;
    int active_clocks;
    int lines;
    int vsync_lines;
    logic read_due;
    logic [31:0] read_expected;
    logic last_active_clock;

    task automatic start_step(input string name);
        step_name = name;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
        input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: %s expected 0x%0h actual 0x%0h", step_name, what,
                expected, actual);
        end
    endtask

    task automatic expect_port_write(input logic [31:0] address, input logic [31:0] word);
        expected_addresses.push_back(address);
        expected_words.push_back(word);
    endtask

    task automatic check_drained();
        if (expected_addresses.size() != 0) begin
            error_count++;
            $display("%0d VRAM data writes never reached a port", expected_addresses.size());
        end
    endtask

    task automatic check_port_pulse();
        logic [31:0] address;
        logic [31:0] word;
        logic odd;
        pulse_count++;
        if (expected_addresses.size() == 0) begin
            error_count++;
            $display("VRAM port pulse with no data write outstanding in step %s", step_name);
        end else begin
            address = expected_addresses.pop_front();
            word = expected_words.pop_front();
            odd = vram_we_odd;
            check_value("write enables high", 1, 32'(vram_we_even) + 32'(vram_we_odd));
            check_value("odd port select", 32'(address[0]), 32'(odd));
            check_value("port address", 32'(address[14:1]),
                32'(odd ? vram_address_odd : vram_address_even));
            check_value("port data", word,
                32'(odd ? vram_write_data_odd : vram_write_data_even));
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            x_model = 0;
            y_model = 0;
            hsync_low = 0;
            active_clocks = 0;
            lines = 0;
            vsync_lines = 0;
            read_due = 1'b0;
        end else begin
            // read data comes one clock after the request
            if (read_due) begin
                check_value("raster readback", read_expected, 32'(host_read_data));
            end
            read_due = host_read_en;
            read_expected = (host_address == READ_RASTER_X) ? 32'(x_model) : 32'(y_model);

            if (vram_we_even || vram_we_odd) begin
                check_port_pulse();
            end

            // last clock of the last active line
            last_active_clock = (x_model == line_clocks - 1) && (y_model == active_lines - 1);
            if (active_frame_ended || last_active_clock) begin
                check_value("active_frame_ended", 32'(last_active_clock),
                    32'(active_frame_ended));
            end

            if (!vga_hsync) begin
                hsync_low++;
            end
            if (active_display) begin
                active_clocks++;
            end

            if (line_ended) begin
                check_value("line period", line_clocks, 32'(x_model + 1));
                check_value("hsync low clocks", hsync_clocks, 32'(hsync_low));
                check_value("active clocks", (y_model < active_lines) ? active_width : 0,
                    32'(active_clocks));
                lines++;
                if (!vga_vsync) begin
                    vsync_lines++;
                end
                if (frame_ended) begin
                    check_value("lines per frame", frame_lines, 32'(lines));
                    check_value("vsync low lines", vsync_lines_expected, 32'(vsync_lines));
                    lines = 0;
                    vsync_lines = 0;
                end
                hsync_low = 0;
                active_clocks = 0;
                x_model = 0;
                y_model = frame_ended ? 0 : y_model + 1;
            end else begin
                x_model++;
            end
        end
    end

endmodule

//--- test/vdp_sva.sv
// assertions on the display processor VRAM ports and line strobe
// bound into the top level, where raster_x and the ports meet
`timescale 1ns/1ps

module vdp_sva (
    input logic clk,
    input logic reset,
    input vdp_pkg::raster_x_t raster_x,
    input logic line_ended,
    input logic vram_we_even,
    input logic vram_we_odd
);

    // port writes land on the edge after the host slot
    assert property (@(posedge clk) disable iff (reset)
        (vram_we_even || vram_we_odd) |-> $past(raster_x[2:0]) == 3'd0)
        else $error("VRAM write enable outside the cycle after the host write slot");

    assert property (@(posedge clk) disable iff (reset)
        !(vram_we_even && vram_we_odd))
        else $error("both VRAM write enables high in one cycle");

    assert property (@(posedge clk) disable iff (reset)
        line_ended |=> !line_ended)
        else $error("line_ended held for more than one cycle");

endmodule

bind vdp vdp_sva sva (
    .clk(clk),
    .reset(reset),
    .raster_x(raster_x),
    .line_ended(line_ended),
    .vram_we_even(vram_we_even),
    .vram_we_odd(vram_we_odd)
);

//--- logic/vdp.sv
// video display processor, host facing core
// raster timing, host registers, VRAM write scheduling and backdrop output
`timescale 1ns/1ps

module vdp #(
    parameter bit enable_widescreen = 1'b0
) (
    input logic clk,
    input logic reset,
    input vdp_pkg::reg_addr_t host_address,
    input vdp_pkg::word_t host_write_data,
    input logic host_write_en,
    input logic host_read_en,
    output vdp_pkg::word_t host_read_data,
    output logic host_ready,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic active_display,
    // single cycle strobes
    output logic line_ended,
    output logic frame_ended,
    output logic active_frame_ended,
    output vdp_pkg::vram_addr_t vram_address_even,
    output vdp_pkg::word_t vram_write_data_even,
    output logic vram_we_even,
    output vdp_pkg::vram_addr_t vram_address_odd,
    output vdp_pkg::word_t vram_write_data_odd,
    output logic vram_we_odd
);
    import vdp_pkg::*;

    raster_x_t raster_x;
    raster_y_t raster_y;
    logic palette_write_en;
    pal_addr_t palette_address;
    word_t palette_data;

    vdp_vram_req_if vram_req ();

    vdp_vga_timing #(
        .enable_widescreen(enable_widescreen)
    ) vga_timing (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .hsync(vga_hsync),
        .vsync(vga_vsync),
        .active_display(active_display),
        .line_ended(line_ended),
        .frame_ended(frame_ended),
        .active_frame_ended(active_frame_ended)
    );

    vdp_register_file register_file (
        .clk(clk),
        .reset(reset),
        .host_address(host_address),
        .host_write_data(host_write_data),
        .host_write_en(host_write_en),
        .host_read_en(host_read_en),
        .raster_x(raster_x),
        .raster_y(raster_y),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .palette_write_en(palette_write_en),
        .palette_address(palette_address),
        .palette_data(palette_data),
        .vram_req(vram_req.reg_file)
    );

    vdp_vram_schedule vram_schedule (
        .clk(clk),
        .reset(reset),
        .raster_x(raster_x),
        .vram_req(vram_req.schedule),
        .vram_address_even(vram_address_even),
        .vram_address_odd(vram_address_odd),
        .vram_write_data_even(vram_write_data_even),
        .vram_write_data_odd(vram_write_data_odd),
        .vram_we_even(vram_we_even),
        .vram_we_odd(vram_we_odd)
    );

    vdp_palette palette (
        .clk(clk),
        .reset(reset),
        .palette_write_en(palette_write_en),
        .palette_address(palette_address),
        .palette_data(palette_data),
        .active_display(active_display),
        .r(r),
        .g(g),
        .b(b)
    );

endmodule

//--- logic/vdp_palette.sv
// palette RAM, 256 words of 4:4:4 colour
// entry 0 is the backdrop, shown during active display and blanked outside it
`timescale 1ns/1ps

module vdp_palette (
    input logic clk,
    input logic reset,
    input logic palette_write_en,
    input vdp_pkg::pal_addr_t palette_address,
    input vdp_pkg::word_t palette_data,
    input logic active_display,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);
    import vdp_pkg::*;

    word_t palette_ram [256];
    word_t palette_output;
    color_t backdrop;
    logic active_display_d;

    always_ff @(posedge clk) begin
        if (palette_write_en) begin
            palette_ram[palette_address] <= palette_data;
        end

        // no layers remain, so the read address is always the backdrop
        palette_output <= palette_ram[0];
    end

    assign backdrop = palette_output[11:0];

    // second stage lines up with the registered RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            active_display_d <= 1'b0;
            {r, g, b} <= '0;
        end else begin
            active_display_d <= active_display;
            {r, g, b} <= active_display_d ? backdrop : color_t'(0);
        end
    end

endmodule

//--- logic/vdp_vram_schedule.sv
// VRAM access sequencer
// eight-cycle groups keyed on raster_x, the host write slot drives the
// registered even and odd ports, the remaining slots are left idle
`timescale 1ns/1ps

module vdp_vram_schedule (
    input logic clk,
    input logic reset,
    input vdp_pkg::raster_x_t raster_x,
    vdp_vram_req_if.schedule vram_req,
    output vdp_pkg::vram_addr_t vram_address_even,
    output vdp_pkg::vram_addr_t vram_address_odd,
    output vdp_pkg::word_t vram_write_data_even,
    output vdp_pkg::word_t vram_write_data_odd,
    output logic vram_we_even,
    output logic vram_we_odd
);
    import vdp_pkg::*;

    localparam int slot_bits = $clog2(SLOT_COUNT);

    logic [slot_bits-1:0] slot;
    logic odd_port;

    assign slot = raster_x[slot_bits-1:0];
    assign vram_req.written = vram_req.pending && (slot == slot_bits'(HOST_WRITE_SLOT));

    // word address bit 0 picks the port
    assign odd_port = vram_req.address[0];

    always_ff @(posedge clk) begin
        if (reset || !vram_req.written) begin
            vram_address_even <= '0;
            vram_address_odd <= '0;
            vram_we_even <= 1'b0;
            vram_we_odd <= 1'b0;
        end else begin
            vram_address_even <= vram_req.address[14:1];
            vram_address_odd <= vram_req.address[14:1];
            vram_we_even <= !odd_port;
            vram_we_odd <= odd_port;
        end
    end

    always_ff @(posedge clk) begin
        if (vram_req.written) begin
            vram_write_data_even <= vram_req.data;
            vram_write_data_odd <= vram_req.data;
        end
    end

endmodule

//--- logic/vdp_register_file.sv
// host register file
// decodes host writes into palette writes and a pending VRAM write,
// and answers raster position reads one clock after the request
`timescale 1ns/1ps

module vdp_register_file (
    input logic clk,
    input logic reset,
    input vdp_pkg::reg_addr_t host_address,
    input vdp_pkg::word_t host_write_data,
    input logic host_write_en,
    input logic host_read_en,
    input vdp_pkg::raster_x_t raster_x,
    input vdp_pkg::raster_y_t raster_y,
    output vdp_pkg::word_t host_read_data,
    output logic host_ready,
    output logic palette_write_en,
    output vdp_pkg::pal_addr_t palette_address,
    output vdp_pkg::word_t palette_data,
    vdp_vram_req_if.reg_file vram_req
);
    import vdp_pkg::*;

    logic [7:0] vram_increment;

    // palette RAM takes the write on the same edge
    assign palette_write_en = host_write_en && (host_address == REG_PALETTE_DATA);
    assign palette_data = host_write_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            palette_address <= '0;
            vram_req.address <= '0;
            vram_req.pending <= 1'b0;
            vram_increment <= '0;
        end else begin
            if (palette_write_en) begin
                palette_address <= palette_address + 1'b1;
            end

            // schedule took the write, step to the next word
            if (vram_req.pending && vram_req.written) begin
                vram_req.pending <= 1'b0;
                vram_req.address <= vram_req.address + vram_word_addr_t'(vram_increment);
            end

            if (host_write_en) begin
                case (host_address)
                    REG_PALETTE_ADDR: palette_address <= host_write_data[7:0];
                    REG_VRAM_ADDR: vram_req.address <= host_write_data[14:0];
                    REG_VRAM_INCREMENT: vram_increment <= host_write_data[7:0];
                    // a write over a pending one replaces it
                    REG_VRAM_DATA: vram_req.pending <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_write_en && host_address == REG_VRAM_DATA) begin
            vram_req.data <= host_write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (host_read_en) begin
            case (host_address)
                READ_RASTER_X: host_read_data <= word_t'(raster_x);
                READ_RASTER_Y: host_read_data <= word_t'(raster_y);
                default: host_read_data <= '0;
            endcase
        end
    end

    assign host_ready = !vram_req.pending;

endmodule

//--- logic/vdp_vga_timing.sv
// VGA raster timing generator
// horizontal blanking leads each line, vertical blanking follows the active lines
// sync levels are active low, strobes last one clock
`timescale 1ns/1ps

module vdp_vga_timing #(
    parameter bit enable_widescreen = 1'b0
) (
    input logic clk,
    input logic reset,
    output vdp_pkg::raster_x_t raster_x,
    output vdp_pkg::raster_y_t raster_y,
    output logic hsync,
    output logic vsync,
    output logic active_display,
    output logic line_ended,
    output logic frame_ended,
    output logic active_frame_ended
);
    import vdp_pkg::*;

    localparam int h_active = enable_widescreen ? H_ACTIVE_848 : H_ACTIVE_640;
    localparam int h_sync = enable_widescreen ? H_SYNC_848 : H_SYNC_640;
    localparam int h_backporch = enable_widescreen ? H_BACKPORCH_848 : H_BACKPORCH_640;
    localparam int v_frontporch = enable_widescreen ? V_FRONTPORCH_848 : V_FRONTPORCH_640;
    localparam int v_sync = enable_widescreen ? V_SYNC_848 : V_SYNC_640;
    localparam int v_backporch = enable_widescreen ? V_BACKPORCH_848 : V_BACKPORCH_640;

    // line layout: front porch, sync, back porch, then active pixels
    localparam raster_x_t hsync_start = raster_x_t'(H_FRONTPORCH);
    localparam raster_x_t hsync_end = raster_x_t'(H_FRONTPORCH + h_sync);
    localparam raster_x_t h_active_start = raster_x_t'(H_FRONTPORCH + h_sync + h_backporch);
    localparam raster_x_t h_last = raster_x_t'(H_FRONTPORCH + h_sync + h_backporch + h_active - 1);

    localparam raster_y_t v_active_last = raster_y_t'(V_ACTIVE_HEIGHT - 1);
    localparam raster_y_t vsync_start = raster_y_t'(V_ACTIVE_HEIGHT + v_frontporch);
    localparam raster_y_t vsync_end = raster_y_t'(V_ACTIVE_HEIGHT + v_frontporch + v_sync);
    localparam raster_y_t v_last =
        raster_y_t'(V_ACTIVE_HEIGHT + v_frontporch + v_sync + v_backporch - 1);

    logic last_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (line_ended) begin
            raster_x <= '0;
            raster_y <= last_line ? '0 : raster_y + 1'b1;
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    assign last_line = raster_y == v_last;

    // strobes decoded from the counter ends
    assign line_ended = raster_x == h_last;
    assign frame_ended = line_ended && last_line;
    assign active_frame_ended = line_ended && (raster_y == v_active_last);

    assign hsync = !(raster_x >= hsync_start && raster_x < hsync_end);
    assign vsync = !(raster_y >= vsync_start && raster_y < vsync_end);
    assign active_display = raster_x >= h_active_start && raster_y <= v_active_last;

endmodule

//--- logic/vdp_vram_req_if.sv
// pending host VRAM write, handed from the register file to the access schedule
// pending holds until the schedule pulses written in its host slot
`timescale 1ns/1ps

interface vdp_vram_req_if;
    import vdp_pkg::*;

    vram_word_addr_t address;
    word_t data;
    logic pending;
    logic written;

    modport reg_file (
        output address, data, pending,
        input written
    );

    modport schedule (
        input address, data, pending,
        output written
    );

endinterface

//--- logic/vdp_pkg.sv
// video display processor shared definitions
// data and address types, host register map, raster timing and VRAM slot constants
package vdp_pkg;

    typedef logic [15:0] word_t;
    typedef logic [13:0] vram_addr_t;
    typedef logic [14:0] vram_word_addr_t;
    typedef logic [7:0] pal_addr_t;
    typedef logic [11:0] color_t;
    typedef logic [11:0] raster_x_t;
    typedef logic [10:0] raster_y_t;
    typedef logic [4:0] reg_addr_t;

    // host write registers
    typedef enum reg_addr_t {
        REG_PALETTE_ADDR = 5'd2,
        REG_PALETTE_DATA = 5'd3,
        REG_VRAM_ADDR = 5'd4,
        REG_VRAM_DATA = 5'd5,
        REG_VRAM_INCREMENT = 5'd6
    } vdp_reg_e;

    // read numbers overlap the write map, so they sit outside the enum
    localparam reg_addr_t READ_RASTER_X = 5'd0;
    localparam reg_addr_t READ_RASTER_Y = 5'd2;

    // 640x480 and 848x480, both at 60Hz
    localparam int H_ACTIVE_640 = 640;
    localparam int H_ACTIVE_848 = 848;
    localparam int H_SYNC_640 = 96;
    localparam int H_SYNC_848 = 112;
    localparam int H_BACKPORCH_640 = 48;
    localparam int H_BACKPORCH_848 = 112;
    localparam int V_FRONTPORCH_640 = 10;
    localparam int V_FRONTPORCH_848 = 6;
    localparam int V_SYNC_640 = 2;
    localparam int V_SYNC_848 = 8;
    localparam int V_BACKPORCH_640 = 33;
    localparam int V_BACKPORCH_848 = 23;
    localparam int H_FRONTPORCH = 16;
    localparam int V_ACTIVE_HEIGHT = 480;

    // VRAM access group, one host slot per eight pixels
    localparam int SLOT_COUNT = 8;
    localparam int HOST_WRITE_SLOT = 0;

endpackage
